//--- pat_pkg.sv
package pat_pkg;

	// ============================================================
	// widths
	// ============================================================
	localparam int d_width        = 8;  // data, acc and memory word
	localparam int i_width        = 20; // instruction word
	localparam int pc_field_width = 16; // pc slot in the pipeline structs, pc_width bits used

	// instruction word layout
	//   [19:15] reserved
	//   [14:13] condition
	//   [12]    reserved
	//   [11:8]  i8 opcode, 4'hf opens the i3 space
	//   [7:4]   i3 opcode, 4'hf opens the i0 space
	//   [3:0]   i0 opcode
	//   [7:0]   i8 immediate, [2:0] i3 immediate

	// ============================================================
	// opcodes
	// ============================================================
	typedef enum logic [3:0] {
		op8_or   = 4'h0,
		op8_and  = 4'h1,
		op8_addm = 4'h2,
		op8_subm = 4'h3,
		op8_add  = 4'h4,
		op8_sub  = 4'h5,
		op8_ldi  = 4'h6,
		op8_ldm  = 4'h7,
		op8_bf   = 4'h8,
		op8_bb   = 4'h9,
		op8_stam = 4'hb,
		op8_orm  = 4'hd,
		op8_andm = 4'he,
		op8_pfx  = 4'hf  // into i3 class
	} opc8_e;

	typedef enum logic [3:0] {
		op3_shl = 4'h0,
		op3_shr = 4'h2,
		op3_asr = 4'h3,
		op3_in  = 4'h5,
		op3_out = 4'h8,
		op3_pfx = 4'hf  // into i0 class
	} opc3_e;

	typedef enum logic [3:0] {
		op0_not = 4'h0,
		op0_nop = 4'hf
	} opc0_e;

	typedef enum logic [3:0] {
		alu_or, alu_and, alu_not, alu_add, alu_sub,
		alu_shl, alu_shr, alu_asr, alu_pass
	} alu_op_e;

	typedef enum logic [1:0] {
		src_alu, // alu result
		src_imm, // immediate straight in
		src_in   // input port
	} src_e;

	typedef enum logic [1:0] {
		cond_zero   = 2'b00,
		cond_neg    = 2'b01,
		cond_dflt   = 2'b10, // also always
		cond_always = 2'b11
	} cond_e;

	// ============================================================
	// pipeline structs
	// ============================================================
	typedef struct packed {
		logic                      valid;
		alu_op_e                   alu_op;
		src_e                      src;
		logic                      mem_rd;  // alu b comes from memory
		logic                      wr_acc;
		logic                      mem_wr;  // stam
		logic                      out;
		logic                      bf;
		logic                      bb;
		cond_e                     cond;
		logic [d_width-1:0]        imm;     // also the memory address
		logic [pc_field_width-1:0] pc;      // own pc, for branch targets
	} pat_ctrl_t;

	typedef struct packed {
		logic [i_width-1:0]        word;
		logic [pc_field_width-1:0] pc;
		logic                      valid;
	} fetch_t;

endpackage

//--- pat_alu.sv
`timescale 1ns/1ps

module pat_alu (
	input  logic [pat_pkg::d_width-1:0] i_a,   // accumulator
	input  logic [pat_pkg::d_width-1:0] i_b,   // memory word or immediate
	input  pat_pkg::alu_op_e            i_op,
	output logic [pat_pkg::d_width-1:0] o_y
);

	localparam int dw = pat_pkg::d_width;

	logic [dw-1:0] b_inv;    // b or ~b
	logic [dw-1:0] addsub;
	logic          is_sub;
	logic [2:0]    shamt;

	// shared adder, sub is a + ~b + 1
	assign is_sub = (i_op == pat_pkg::alu_sub);
	assign b_inv  = is_sub ? ~i_b : i_b;
	assign addsub = i_a + b_inv + dw'(is_sub);  // wraps mod 2^dw

	assign shamt = i_b[2:0];  // only low bits count

	always_comb
	begin
		case (i_op)
			pat_pkg::alu_or:   o_y = i_a | i_b;
			pat_pkg::alu_and:  o_y = i_a & i_b;
			pat_pkg::alu_not:  o_y = ~i_a;
			pat_pkg::alu_add,
			pat_pkg::alu_sub:  o_y = addsub;
			pat_pkg::alu_shl:  o_y = i_a << shamt;                       // zero fill
			pat_pkg::alu_shr:  o_y = i_a >> shamt;                       // zero fill
			pat_pkg::alu_asr:  o_y = dw'($signed(i_a) >>> shamt);        // sign fill
			pat_pkg::alu_pass: o_y = i_b;   // ldm
			default:           o_y = i_b;
		endcase
	end

endmodule

//--- pat_data_mem.sv
`timescale 1ns/1ps

module pat_data_mem #(
	parameter int dmem_depth = 32
) (
	input  logic                          clk,
	input  logic [$clog2(dmem_depth)-1:0] i_rd_adr,
	input  logic [$clog2(dmem_depth)-1:0] i_wr_adr,
	input  logic                          i_wr_en,
	input  logic [pat_pkg::d_width-1:0]   i_wr_data,
	output logic [pat_pkg::d_width-1:0]   o_rd_data
);

	logic [pat_pkg::d_width-1:0] mem [dmem_depth];

	// read straight through, same cycle
	assign o_rd_data = mem[i_rd_adr];

	// write lands on the edge, next cycle reads it
	always_ff @(posedge clk)
	begin
		if (i_wr_en)
			mem[i_wr_adr] <= i_wr_data;
	end

endmodule

//--- pat_fetch.sv
`timescale 1ns/1ps

module pat_fetch #(
	parameter int pc_width = 10
) (
	input  logic                         i_clk,
	input  logic                         i_reset,
	input  logic [pat_pkg::i_width-1:0]  i_instruction,
	input  logic                         i_redirect,  // taken branch from execute
	input  logic [pc_width-1:0]          i_target,
	output logic [pc_width-1:0]          o_pc,
	output pat_pkg::fetch_t              o_fetch
);

	localparam int pc_fw = pat_pkg::pc_field_width;

	logic [pc_width-1:0] pc;
	logic [pc_width-1:0] pc_next;

	// ============================================================
	// program counter
	// ============================================================
	// one word per cycle, no stall
	always_comb
	begin
		if (i_redirect)
			pc_next = i_target;        // branch wins
		else
			pc_next = pc + 1'b1;       // wraps at pc_width
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			pc <= '0;
		else
			pc <= pc_next;
	end

	assign o_pc = pc;

	// ============================================================
	// fetch register
	// ============================================================
	// word returned for o_pc lands here with the pc it came from
	always_ff @(posedge i_clk)
	begin
		o_fetch.word <= i_instruction;
		o_fetch.pc   <= pc_fw'(pc);
		if (i_reset || i_redirect)
			o_fetch.valid <= 1'b0;     // squash the word behind a branch
		else
			o_fetch.valid <= 1'b1;
	end

endmodule

//--- pat_decoder.sv
`timescale 1ns/1ps

module pat_decoder #(
	parameter int pc_width = 10
) (
	input  logic               clk,
	input  logic               reset,
	input  pat_pkg::fetch_t    i_fetch,
	input  logic               i_flush,   // redirect from execute
	output pat_pkg::pat_ctrl_t o_ctrl
);

	localparam int pc_fw = pat_pkg::pc_field_width;

	pat_pkg::opc8_e     op8;
	pat_pkg::opc3_e     op3;
	pat_pkg::opc0_e     op0;
	pat_pkg::pat_ctrl_t ctrl_d;

	// field split
	assign op8 = pat_pkg::opc8_e'(i_fetch.word[11:8]);
	assign op3 = pat_pkg::opc3_e'(i_fetch.word[7:4]);
	assign op0 = pat_pkg::opc0_e'(i_fetch.word[3:0]);

	always_comb
	begin
		ctrl_d        = '0;
		ctrl_d.valid  = i_fetch.valid;
		ctrl_d.alu_op = pat_pkg::alu_pass;
		ctrl_d.src    = pat_pkg::src_alu;
		ctrl_d.cond   = pat_pkg::cond_e'(i_fetch.word[14:13]);
		ctrl_d.imm    = i_fetch.word[7:0];
		ctrl_d.pc     = pc_fw'(i_fetch.pc[pc_width-1:0]);

		if (op8 != pat_pkg::op8_pfx)
		begin
			// i8 class
			case (op8)
				pat_pkg::op8_or:   begin ctrl_d.alu_op = pat_pkg::alu_or;  ctrl_d.wr_acc = 1'b1; end
				pat_pkg::op8_and:  begin ctrl_d.alu_op = pat_pkg::alu_and; ctrl_d.wr_acc = 1'b1; end
				pat_pkg::op8_add:  begin ctrl_d.alu_op = pat_pkg::alu_add; ctrl_d.wr_acc = 1'b1; end
				pat_pkg::op8_sub:  begin ctrl_d.alu_op = pat_pkg::alu_sub; ctrl_d.wr_acc = 1'b1; end
				pat_pkg::op8_addm: begin ctrl_d.alu_op = pat_pkg::alu_add; ctrl_d.mem_rd = 1'b1; ctrl_d.wr_acc = 1'b1; end
				pat_pkg::op8_subm: begin ctrl_d.alu_op = pat_pkg::alu_sub; ctrl_d.mem_rd = 1'b1; ctrl_d.wr_acc = 1'b1; end
				pat_pkg::op8_orm:  begin ctrl_d.alu_op = pat_pkg::alu_or;  ctrl_d.mem_rd = 1'b1; ctrl_d.wr_acc = 1'b1; end
				pat_pkg::op8_andm: begin ctrl_d.alu_op = pat_pkg::alu_and; ctrl_d.mem_rd = 1'b1; ctrl_d.wr_acc = 1'b1; end
				pat_pkg::op8_ldm:  begin ctrl_d.mem_rd = 1'b1; ctrl_d.wr_acc = 1'b1; end // pass b
				pat_pkg::op8_ldi:  begin ctrl_d.src = pat_pkg::src_imm; ctrl_d.wr_acc = 1'b1; end
				pat_pkg::op8_stam: ctrl_d.mem_wr = 1'b1;
				pat_pkg::op8_bf:   ctrl_d.bf = 1'b1;
				pat_pkg::op8_bb:   ctrl_d.bb = 1'b1;
				default:           ctrl_d.valid = 1'b0; // dropped opcode, bubble
			endcase
		end
		else if (op3 != pat_pkg::op3_pfx)
		begin
			// i3 class, 3 bit immediate zero extended
			ctrl_d.imm = {5'b0, i_fetch.word[2:0]};
			case (op3)
				pat_pkg::op3_shl: begin ctrl_d.alu_op = pat_pkg::alu_shl; ctrl_d.wr_acc = 1'b1; end
				pat_pkg::op3_shr: begin ctrl_d.alu_op = pat_pkg::alu_shr; ctrl_d.wr_acc = 1'b1; end
				pat_pkg::op3_asr: begin ctrl_d.alu_op = pat_pkg::alu_asr; ctrl_d.wr_acc = 1'b1; end
				pat_pkg::op3_in:  begin ctrl_d.src = pat_pkg::src_in; ctrl_d.wr_acc = 1'b1; end
				pat_pkg::op3_out: ctrl_d.out = 1'b1;
				default:          ctrl_d.valid = 1'b0;
			endcase
		end
		else
		begin
			// i0 class
			case (op0)
				pat_pkg::op0_not: begin ctrl_d.alu_op = pat_pkg::alu_not; ctrl_d.wr_acc = 1'b1; end
				pat_pkg::op0_nop: ; // valid, does nothing
				default:          ctrl_d.valid = 1'b0;
			endcase
		end
	end

	// control register
	always_ff @(posedge clk)
	begin
		o_ctrl <= ctrl_d;
		if (reset || i_flush)
			o_ctrl.valid <= 1'b0;  // kill on branch
	end

endmodule

//--- pat_execute.sv
`timescale 1ns/1ps

module pat_execute #(
	parameter int pc_width = 10
) (
	input  logic                        clk,
	input  logic                        reset,
	input  pat_pkg::pat_ctrl_t          i_ctrl,
	input  logic [pat_pkg::d_width-1:0] i_inputs,
	input  logic [pat_pkg::d_width-1:0] i_mem_rd_data,
	output logic [pat_pkg::d_width-1:0] o_mem_rd_adr,
	output logic [pat_pkg::d_width-1:0] o_mem_wr_adr,
	output logic                        o_mem_wr_en,
	output logic [pat_pkg::d_width-1:0] o_mem_wr_data,
	output logic                        o_redirect,
	output logic [pc_width-1:0]         o_target,
	output logic [pat_pkg::d_width-1:0] o_acc,
	output logic [pat_pkg::d_width-1:0] o_outputs
);

	localparam int dw = pat_pkg::d_width;

	logic [dw-1:0]       acc;
	logic                z, n;     // flags from last acc write
	logic                cond_ok;
	logic                commit;
	logic [dw-1:0]       alu_b;
	logic [dw-1:0]       alu_y;
	logic [dw-1:0]       result;
	logic [pc_width-1:0] own_pc;

	// ============================================================
	// condition and operands
	// ============================================================
	always_comb
	begin
		case (i_ctrl.cond)
			pat_pkg::cond_zero: cond_ok = z;
			pat_pkg::cond_neg:  cond_ok = n;
			default:            cond_ok = 1'b1;  // both always codes
		endcase
	end

	assign commit = i_ctrl.valid && cond_ok;
	assign alu_b  = i_ctrl.mem_rd ? i_mem_rd_data : i_ctrl.imm;

	pat_alu u_alu (
		.i_a  (acc),
		.i_b  (alu_b),
		.i_op (i_ctrl.alu_op),
		.o_y  (alu_y)
	);

	assign result = (i_ctrl.src == pat_pkg::src_imm) ? i_ctrl.imm :
	                (i_ctrl.src == pat_pkg::src_in)  ? i_inputs : alu_y;

	// memory port, address is the immediate
	assign o_mem_rd_adr  = i_ctrl.imm;
	assign o_mem_wr_adr  = i_ctrl.imm;
	assign o_mem_wr_data = acc;
	assign o_mem_wr_en   = commit && i_ctrl.mem_wr;

	// branch, relative to own pc, wraps
	assign own_pc     = i_ctrl.pc[pc_width-1:0];
	assign o_target   = i_ctrl.bb ? own_pc - pc_width'(i_ctrl.imm) : own_pc + pc_width'(i_ctrl.imm);
	assign o_redirect = commit && (i_ctrl.bf || i_ctrl.bb);

	// ============================================================
	// commit
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc       <= '0;
			z         <= 1'b1;   // acc is zero
			n         <= 1'b0;
			o_outputs <= '0;
		end
		else
		begin
			if (commit && i_ctrl.wr_acc)
			begin
				acc <= result;
				z   <= (result == '0);
				n   <= result[dw-1];
			end
			if (commit && i_ctrl.out)
				o_outputs <= acc;
		end
	end

	assign o_acc = acc;

endmodule

//--- pat_top.sv
`timescale 1ns/1ps

module pat_top #(
	parameter int pc_width   = 10,
	parameter int dmem_depth = 32
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [pat_pkg::i_width-1:0] i_instruction,
	input  logic [pat_pkg::d_width-1:0] i_inputs,
	output logic [pc_width-1:0]         o_pc,
	output logic [pat_pkg::d_width-1:0] o_acc,
	output logic [pat_pkg::d_width-1:0] o_outputs
);

	localparam int adr_w = $clog2(dmem_depth);

	pat_pkg::fetch_t             fetch_q;
	pat_pkg::pat_ctrl_t          ctrl_q;
	logic                        redirect;
	logic [pc_width-1:0]         target;
	logic [pat_pkg::d_width-1:0] mem_rd_adr, mem_wr_adr;
	logic [pat_pkg::d_width-1:0] mem_rd_data, mem_wr_data;
	logic                        mem_wr_en;

	// stage 1
	pat_fetch #(.pc_width(pc_width)) u_fetch (
		.i_clk         (clk),
		.i_reset       (reset),
		.i_instruction (i_instruction),
		.i_redirect    (redirect),
		.i_target      (target),
		.o_pc          (o_pc),
		.o_fetch       (fetch_q)
	);

	// stage 2
	pat_decoder #(.pc_width(pc_width)) u_decoder (
		.clk     (clk),
		.reset   (reset),
		.i_fetch (fetch_q),
		.i_flush (redirect),
		.o_ctrl  (ctrl_q)
	);

	// stage 3
	pat_execute #(.pc_width(pc_width)) u_execute (
		.clk           (clk),
		.reset         (reset),
		.i_ctrl        (ctrl_q),
		.i_inputs      (i_inputs),
		.i_mem_rd_data (mem_rd_data),
		.o_mem_rd_adr  (mem_rd_adr),
		.o_mem_wr_adr  (mem_wr_adr),
		.o_mem_wr_en   (mem_wr_en),
		.o_mem_wr_data (mem_wr_data),
		.o_redirect    (redirect),
		.o_target      (target),
		.o_acc         (o_acc),
		.o_outputs     (o_outputs)
	);

	// low address bits only
	pat_data_mem #(.dmem_depth(dmem_depth)) u_dmem (
		.clk       (clk),
		.i_rd_adr  (mem_rd_adr[adr_w-1:0]),
		.i_wr_adr  (mem_wr_adr[adr_w-1:0]),
		.i_wr_en   (mem_wr_en),
		.i_wr_data (mem_wr_data),
		.o_rd_data (mem_rd_data)
	);

endmodule

//--- tb_pat.sv
`timescale 1ns/1ps

module tb_pat;

	localparam int pc_width   = 10;
	localparam int dmem_depth = 32;
	localparam int n_tests    = 8;
	localparam int run_cycles = 40;  // per program, after reset

	localparam logic [1:0] al = pat_pkg::cond_always;
	localparam logic [1:0] cz = pat_pkg::cond_zero;
	localparam logic [1:0] cn = pat_pkg::cond_neg;

	logic                  clk = 1'b0;
	logic                  reset;
	logic [19:0]           instruction;
	logic [7:0]            inputs;
	logic [pc_width-1:0]   pc;
	logic [7:0]            acc;
	logic [7:0]            outputs;

	logic [19:0]           rom [8];          // program ROM, answers o_pc
	string                 test_name [n_tests];
	logic [8*20-1:0]       test_prog [n_tests];  // word 0 in the top bits
	logic [7:0]            test_inputs [n_tests];
	logic [7:0]            test_acc [n_tests];
	logic [7:0]            test_out [n_tests];
	logic [pc_width-1:0]   test_pc [n_tests];    // o_pc at the check
	int                    n_loaded;
	int                    errors;
	int                    checks;

	// ============================================================
	// instruction encoding
	// ============================================================
	// 8 bit immediate class
	function automatic logic [19:0] word_imm8(input logic [1:0] cond, input logic [3:0] op,
		input logic [7:0] imm);
		return {5'b0, cond, 1'b0, op, imm};
	endfunction

	// 3 bit immediate class, behind the 4'hf prefix
	function automatic logic [19:0] word_imm3(input logic [1:0] cond, input logic [3:0] op,
		input logic [2:0] imm);
		return {5'b0, cond, 1'b0, 4'hf, op, 1'b0, imm};
	endfunction

	function automatic logic [19:0] word_noarg(input logic [1:0] cond, input logic [3:0] op);
		return {5'b0, cond, 1'b0, 4'hf, 4'hf, op};  // two prefixes deep
	endfunction

	// ============================================================
	// DUT, clock and program ROM
	// ============================================================
	pat_top #(.pc_width(pc_width), .dmem_depth(dmem_depth)) u_dut (
		.clk           (clk),
		.reset         (reset),
		.i_instruction (instruction),
		.i_inputs      (inputs),
		.o_pc          (pc),
		.o_acc         (acc),
		.o_outputs     (outputs)
	);

	always #5 clk = ~clk;

	// past the program end the core only sees nop
	assign instruction = (pc < pc_width'(8)) ? rom[pc[2:0]] : word_noarg(al, pat_pkg::op0_nop);

	// watchdog, every test takes well under 50 cycles
	initial
	begin
		#(n_tests * 50 * 10);
		$display("watchdog expired, the run did not finish in time");
		$display("Test failures found");
		$finish;
	end

	// ============================================================
	// stimulus table
	// ============================================================
	task automatic add_test(input string name, input logic [8*20-1:0] prog,
		input logic [7:0] in_val, input logic [7:0] exp_acc, input logic [7:0] exp_out,
		input logic [pc_width-1:0] exp_pc);
		test_name[n_loaded]   = name;
		test_prog[n_loaded]   = prog;
		test_inputs[n_loaded] = in_val;
		test_acc[n_loaded]    = exp_acc;
		test_out[n_loaded]    = exp_out;
		test_pc[n_loaded]     = exp_pc;
		n_loaded++;
	endtask

	// o_pc at the check is p + (40 - f) % 3 for bb 0 at p first fetched in cycle f
	task automatic fill_table();
		// 5a|0f=5f, &3c=1c, out, ~1c=e3
		// bb 0 at pc5 from cycle 5
		add_test("logic_ops", {word_imm8(al, pat_pkg::op8_ldi, 8'h5a),
			word_imm8(al, pat_pkg::op8_or, 8'h0f), word_imm8(al, pat_pkg::op8_and, 8'h3c),
			word_imm3(al, pat_pkg::op3_out, 3'd0), word_noarg(al, pat_pkg::op0_not),
			word_imm8(al, pat_pkg::op8_bb, 8'h00), word_noarg(al, pat_pkg::op0_nop),
			word_noarg(al, pat_pkg::op0_nop)}, 8'h00, 8'he3, 8'h1c, pc_width'(7));
		// f0+20 wraps to 10, -30 wraps to e0, asr 2 = f8, shl 3 = c0, shr 5 = 06
		// bb 0 at pc7 from cycle 7
		add_test("arith_shift", {word_imm8(al, pat_pkg::op8_ldi, 8'hf0),
			word_imm8(al, pat_pkg::op8_add, 8'h20), word_imm8(al, pat_pkg::op8_sub, 8'h30),
			word_imm3(al, pat_pkg::op3_asr, 3'd2), word_imm3(al, pat_pkg::op3_out, 3'd0),
			word_imm3(al, pat_pkg::op3_shl, 3'd3), word_imm3(al, pat_pkg::op3_shr, 3'd5),
			word_imm8(al, pat_pkg::op8_bb, 8'h00)}, 8'h00, 8'h06, 8'hf8, pc_width'(7));
		// m4=3c m5=81, addm 5 right after its store: 81+81=02, 02-3c=c6
		// bb 0 at pc7 from cycle 7
		add_test("mem_add_sub", {word_imm8(al, pat_pkg::op8_ldi, 8'h3c),
			word_imm8(al, pat_pkg::op8_stam, 8'd4), word_imm8(al, pat_pkg::op8_ldi, 8'h81),
			word_imm8(al, pat_pkg::op8_stam, 8'd5), word_imm8(al, pat_pkg::op8_addm, 8'd5),
			word_imm8(al, pat_pkg::op8_subm, 8'd4), word_imm3(al, pat_pkg::op3_out, 3'd0),
			word_imm8(al, pat_pkg::op8_bb, 8'h00)}, 8'h00, 8'hc6, 8'hc6, pc_width'(7));
		// m6=c3 m7=5a, ldm 6, out, c3&5a=42
		// bb 0 at pc7 from cycle 7
		add_test("mem_load_and", {word_imm8(al, pat_pkg::op8_ldi, 8'hc3),
			word_imm8(al, pat_pkg::op8_stam, 8'd6), word_imm8(al, pat_pkg::op8_ldi, 8'h5a),
			word_imm8(al, pat_pkg::op8_stam, 8'd7), word_imm8(al, pat_pkg::op8_ldm, 8'd6),
			word_imm3(al, pat_pkg::op3_out, 3'd0), word_imm8(al, pat_pkg::op8_andm, 8'd7),
			word_imm8(al, pat_pkg::op8_bb, 8'h00)}, 8'h00, 8'h42, 8'hc3, pc_width'(7));
		// m8=81, 24|81=a5, out, ~a5=5a
		// bb 0 at pc6 from cycle 6
		add_test("mem_or", {word_imm8(al, pat_pkg::op8_ldi, 8'h81),
			word_imm8(al, pat_pkg::op8_stam, 8'd8), word_imm8(al, pat_pkg::op8_ldi, 8'h24),
			word_imm8(al, pat_pkg::op8_orm, 8'd8), word_imm3(al, pat_pkg::op3_out, 3'd0),
			word_noarg(al, pat_pkg::op0_not), word_imm8(al, pat_pkg::op8_bb, 8'h00),
			word_noarg(al, pat_pkg::op0_nop)}, 8'h00, 8'h5a, 8'ha5, pc_width'(7));
		// in 9c sets n, add.n passes, ldi.z fails on z=0
		// bb 0 at pc4 from cycle 4
		add_test("input_cond", {word_imm3(al, pat_pkg::op3_in, 3'd0),
			word_imm3(al, pat_pkg::op3_out, 3'd0), word_imm8(cn, pat_pkg::op8_add, 8'h01),
			word_imm8(cz, pat_pkg::op8_ldi, 8'h11), word_imm8(al, pat_pkg::op8_bb, 8'h00),
			word_noarg(al, pat_pkg::op0_nop), word_noarg(al, pat_pkg::op0_nop),
			word_noarg(al, pat_pkg::op0_nop)}, 8'h9c, 8'h9d, 8'h9c, pc_width'(4));
		// bf.z at pc1 jumps to pc5, the two ors behind it and the ldi never land
		// pc5 in cycle 4, so bb 0 at pc7 from cycle 6
		add_test("branch_skip", {word_imm8(al, pat_pkg::op8_ldi, 8'h00),
			word_imm8(cz, pat_pkg::op8_bf, 8'd4), word_imm8(al, pat_pkg::op8_or, 8'h40),
			word_imm8(al, pat_pkg::op8_or, 8'h80), word_imm8(al, pat_pkg::op8_ldi, 8'h77),
			word_imm8(al, pat_pkg::op8_or, 8'h21), word_imm3(al, pat_pkg::op3_out, 3'd0),
			word_imm8(al, pat_pkg::op8_bb, 8'h00)}, 8'h00, 8'h21, 8'h21, pc_width'(8));
		// three passes of sub 1 bring 3 to zero, bf.z leaves, then +20
		// bf taken at edge 15, bb 0 at pc6 from cycle 17
		add_test("count_loop", {word_imm8(al, pat_pkg::op8_ldi, 8'h03),
			word_imm8(al, pat_pkg::op8_sub, 8'h01), word_imm8(cz, pat_pkg::op8_bf, 8'd2),
			word_imm8(al, pat_pkg::op8_bb, 8'd2), word_imm8(al, pat_pkg::op8_add, 8'h20),
			word_imm3(al, pat_pkg::op3_out, 3'd0), word_imm8(al, pat_pkg::op8_bb, 8'h00),
			word_noarg(al, pat_pkg::op0_nop)}, 8'h00, 8'h20, 8'h20, pc_width'(8));
	endtask

	// ============================================================
	// run and check
	// ============================================================
	task automatic check_port(input string name, input string port,
		input logic [7:0] expected, input logic [7:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("CHECK FAILED %s %s expected %h actual %h", name, port, expected, actual);
			errors++;
		end
	endtask

	task automatic check_pc(input string name, input logic [pc_width-1:0] expected,
		input logic [pc_width-1:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("CHECK FAILED %s o_pc expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic run_test(input int t);
		@(posedge clk);
		#1;
		reset  = 1'b1;
		inputs = test_inputs[t];
		for (int k = 0; k < 8; k++)
			rom[k] = test_prog[t][(7-k)*20 +: 20];  // first listed word at pc 0
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (run_cycles) @(posedge clk);  // program settles in its bb 0 loop
		#1;
		check_port(test_name[t], "o_acc", test_acc[t], acc);
		check_port(test_name[t], "o_outputs", test_out[t], outputs);
		check_pc(test_name[t], test_pc[t], pc);
	endtask

	initial
	begin
		reset    = 1'b1;
		inputs   = 8'h00;
		errors   = 0;
		checks   = 0;
		n_loaded = 0;
		for (int k = 0; k < 8; k++)
			rom[k] = word_noarg(al, pat_pkg::op0_nop);
		fill_table();
		for (int t = 0; t < n_loaded; t++)
			run_test(t);
		$display("summary: %0d tests, %0d checks, %0d errors", n_loaded, checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- build.f
pat_pkg.sv
pat_alu.sv
pat_data_mem.sv
pat_fetch.sv
pat_decoder.sv
pat_execute.sv
pat_top.sv
tb_pat.sv

//--- Makefile
# Verilator flow for the accumulator core testbench

TOP = tb_pat

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f build.f

# pass only when the pass message shows up as a line of its own
run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qxF "All tests passed!"

clean:
	rm -rf obj_dir
